// ==== rv_pkg.sv ====
`default_nettype none

package rv_pkg;

    // Major opcode, instruction bits 6:2
    typedef enum logic [4:0] {
        LOAD     = 5'b00000,
        MISC_MEM = 5'b00011,
        OP_IMM   = 5'b00100,
        AUIPC    = 5'b00101,
        STORE    = 5'b01000,
        OP       = 5'b01100,
        LUI      = 5'b01101,
        BRANCH   = 5'b11000,
        JALR     = 5'b11001,
        JAL      = 5'b11011,
        SYSTEM   = 5'b11100
    } opcode_e;

    typedef enum logic [3:0] {
        ADD  = 4'd0,
        SUB  = 4'd1,
        SLL  = 4'd2,
        SLT  = 4'd3,
        SLTU = 4'd4,
        XOR  = 4'd5,
        SRL  = 4'd6,
        SRA  = 4'd7,
        OR   = 4'd8,
        AND  = 4'd9
    } alu_op_e;

    typedef enum logic [2:0] {
        CLS_ALU     = 3'd0,
        CLS_LUI     = 3'd1,
        CLS_AUIPC   = 3'd2,
        CLS_JAL     = 3'd3,
        CLS_JALR    = 3'd4,
        CLS_BRANCH  = 3'd5,
        CLS_ILLEGAL = 3'd6
    } inst_class_e;

    typedef enum logic [2:0] {
        ST_FETCH_ADDR = 3'd0,
        ST_FETCH_DATA = 3'd1,
        ST_EXECUTE    = 3'd2,
        ST_HALT       = 3'd3
    } core_state_e;

    typedef enum logic [1:0] {
        TRAP_NONE       = 2'd0,
        TRAP_ILLEGAL    = 2'd1,
        TRAP_MISALIGNED = 2'd2,
        TRAP_BUS        = 2'd3
    } trap_cause_e;

    localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

endpackage

`default_nettype wire

// ==== instr_decoder.sv ====
`timescale 1ns/100ps
`default_nettype none

module instr_decoder (
    input  wire logic [31:0]    inst,
    output logic [4:0]          rd,
    output logic [4:0]          rs1,
    output logic [4:0]          rs2,
    output logic [31:0]         imm,
    output rv_pkg::alu_op_e     alu_op,
    output rv_pkg::inst_class_e inst_class,
    output logic [2:0]          branch_func
);
    import rv_pkg::*;

    opcode_e     opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [31:0] imm_i;
    logic [31:0] imm_u;
    logic [31:0] imm_j;
    logic [31:0] imm_b;

    // funct3 to ALU operation, alt selects SUB or SRA
    function automatic alu_op_e alu_dec(input logic [2:0] f3, input logic alt);
        alu_op_e op;
        case (f3)
            3'b000:  op = alt ? SUB : ADD;
            3'b001:  op = SLL;
            3'b010:  op = SLT;
            3'b011:  op = SLTU;
            3'b100:  op = XOR;
            3'b101:  op = alt ? SRA : SRL;
            3'b110:  op = OR;
            default: op = AND;
        endcase
        return op;
    endfunction

    assign opcode = opcode_e'(inst[6:2]);
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
    assign imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};

    assign rd          = inst[11:7];
    assign rs1         = inst[19:15];
    assign rs2         = inst[24:20];
    assign branch_func = funct3;

    always_comb begin
        imm        = imm_i;
        alu_op     = ADD;
        inst_class = CLS_ILLEGAL;
        case (opcode)
            OP: begin
                // Only bit 30 may be set, and only for SUB and SRA
                if (funct7 == 7'b0000000 ||
                    (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101))) begin
                    inst_class = CLS_ALU;
                    alu_op     = alu_dec(funct3, inst[30]);
                end
            end
            OP_IMM: begin
                alu_op = alu_dec(funct3, funct3 == 3'b101 && inst[30]);
                if (funct3 == 3'b001) begin
                    if (funct7 == 7'b0000000)
                        inst_class = CLS_ALU;
                end else if (funct3 == 3'b101) begin
                    if (funct7 == 7'b0000000 || funct7 == 7'b0100000)
                        inst_class = CLS_ALU;
                end else begin
                    inst_class = CLS_ALU;
                end
            end
            LUI: begin
                imm        = imm_u;
                inst_class = CLS_LUI;
            end
            AUIPC: begin
                imm        = imm_u;
                inst_class = CLS_AUIPC;
            end
            JAL: begin
                imm        = imm_j;
                inst_class = CLS_JAL;
            end
            JALR: begin
                if (funct3 == 3'b000)
                    inst_class = CLS_JALR;
            end
            BRANCH: begin
                imm = imm_b;
                if (funct3 != 3'b010 && funct3 != 3'b011)
                    inst_class = CLS_BRANCH;
            end
            LOAD, STORE, SYSTEM, MISC_MEM: inst_class = CLS_ILLEGAL; // Not in this core
            default: inst_class = CLS_ILLEGAL;
        endcase
        if (inst[1:0] != 2'b11)
            inst_class = CLS_ILLEGAL; // Compressed or reserved encoding
    end

endmodule

`default_nettype wire

// ==== alu.sv ====
`timescale 1ns/100ps
`default_nettype none

module alu (
    input  wire logic [31:0]     a,
    input  wire logic [31:0]     b,
    input  wire rv_pkg::alu_op_e alu_op,
    input  wire logic [2:0]      branch_func,
    output logic [31:0]          result,
    output logic                 branch_taken
);
    import rv_pkg::*;

    logic [4:0] shamt;
    logic       lt_s;
    logic       lt_u;
    logic       eq;

    assign shamt = b[4:0];
    assign lt_s  = $signed(a) < $signed(b);
    assign lt_u  = a < b;
    assign eq    = a == b;

    always_comb begin
        case (alu_op)
            ADD:     result = a + b;
            SUB:     result = a - b;
            SLL:     result = a << shamt;
            SLT:     result = {31'b0, lt_s};
            SLTU:    result = {31'b0, lt_u};
            XOR:     result = a ^ b;
            SRL:     result = a >> shamt;
            SRA:     result = $unsigned($signed(a) >>> shamt);
            OR:      result = a | b;
            AND:     result = a & b;
            default: result = 32'b0;
        endcase
    end

    // Branch compare on funct3
    always_comb begin
        case (branch_func)
            3'b000:  branch_taken = eq;    // BEQ
            3'b001:  branch_taken = !eq;   // BNE
            3'b100:  branch_taken = lt_s;  // BLT
            3'b101:  branch_taken = !lt_s; // BGE
            3'b110:  branch_taken = lt_u;  // BLTU
            3'b111:  branch_taken = !lt_u; // BGEU
            default: branch_taken = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// ==== reg_file.sv ====
`timescale 1ns/100ps
`default_nettype none

module reg_file (
    input  wire logic        clk,
    input  wire logic        rst_n,
    input  wire logic [4:0]  rs1,
    input  wire logic [4:0]  rs2,
    output logic [31:0]      rs1_data,
    output logic [31:0]      rs2_data,
    input  wire logic        we,
    input  wire logic [4:0]  rd,
    input  wire logic [31:0] wdata
);

    logic [31:0] regs [32];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++)
                regs[i] <= 32'b0;
        end else if (we && rd != 5'd0) begin
            regs[rd] <= wdata; // x0 never written
        end
    end

    assign rs1_data = regs[rs1];
    assign rs2_data = regs[rs2];

    x0_reads_zero: assert property (
        @(posedge clk) disable iff (!rst_n)
        (rs1 == 5'd0 |-> rs1_data == 32'b0) and (rs2 == 5'd0 |-> rs2_data == 32'b0)
    );

endmodule

`default_nettype wire

// ==== pc_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module pc_unit #(
    parameter logic [31:0] reset_pc = 32'h0000_0000
) (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire logic                 pc_update,
    input  wire rv_pkg::inst_class_e  inst_class,
    input  wire logic                 branch_taken,
    input  wire logic [31:0]          imm,
    input  wire logic [31:0]          rs1_data,
    output logic [31:0]               pc,
    output logic [31:0]               link,
    output logic                      misaligned
);
    import rv_pkg::*;

    logic [31:0] target;
    logic        take;
    logic [31:0] next_pc;

    assign link   = pc + 32'd4;
    assign target = (inst_class == CLS_JALR) ? ((rs1_data + imm) & ~32'd1) : pc + imm;
    assign take   = (inst_class == CLS_JAL) || (inst_class == CLS_JALR) ||
                    (inst_class == CLS_BRANCH && branch_taken);

    assign next_pc    = take ? target : link;
    assign misaligned = take && target[1]; // Bit 0 is never set here

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            pc <= reset_pc;
        else if (pc_update)
            pc <= next_pc;
    end

    // Holds only while the controller blocks misaligned updates
    pc_word_aligned: assert property (
        @(posedge clk) disable iff (!rst_n) pc[1:0] == 2'b00
    );

endmodule

`default_nettype wire

// ==== core_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module core_ctrl (
    input  wire logic                clk,
    input  wire logic                rst_n,
    output logic                     arvalid,
    input  wire logic                arready,
    input  wire logic                rvalid,
    output logic                     rready,
    input  wire logic [31:0]         rdata,
    input  wire logic [1:0]          rresp,
    output logic [31:0]              inst,
    input  wire rv_pkg::inst_class_e inst_class,
    input  wire logic [4:0]          rd,
    input  wire logic [31:0]         wdata,
    input  wire logic                misaligned,
    input  wire logic [31:0]         pc,
    output logic                     pc_update,
    output logic                     reg_we,
    output logic                     retire_valid,
    output logic [31:0]              retire_pc,
    output logic [4:0]               retire_rd,
    output logic [31:0]              retire_wdata,
    output logic                     halted,
    output rv_pkg::trap_cause_e      trap_cause,
    output logic [31:0]              trap_pc
);
    import rv_pkg::*;

    core_state_e state;
    logic        writes_rd;
    logic        commit;

    assign writes_rd = inst_class inside {CLS_ALU, CLS_LUI, CLS_AUIPC, CLS_JAL, CLS_JALR};
    assign commit    = (state == ST_EXECUTE) && (inst_class != CLS_ILLEGAL) && !misaligned;
    assign pc_update = commit;
    assign reg_we    = commit && writes_rd;
    assign rready    = (state == ST_FETCH_DATA);
    assign halted    = (state == ST_HALT);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= ST_FETCH_ADDR;
            arvalid      <= 1'b0;
            retire_valid <= 1'b0;
            trap_cause   <= TRAP_NONE;
            trap_pc      <= 32'b0;
        end else begin
            retire_valid <= 1'b0;
            case (state)
                ST_FETCH_ADDR: begin
                    if (arvalid && arready) begin
                        arvalid <= 1'b0;
                        state   <= ST_FETCH_DATA;
                    end else begin
                        arvalid <= 1'b1; // First request after reset
                    end
                end
                ST_FETCH_DATA: begin
                    if (rvalid) begin
                        if (rresp != AXI_RESP_OKAY) begin
                            trap_cause <= TRAP_BUS;
                            trap_pc    <= pc;
                            state      <= ST_HALT;
                        end else begin
                            state <= ST_EXECUTE;
                        end
                    end
                end
                ST_EXECUTE: begin
                    if (inst_class == CLS_ILLEGAL) begin
                        trap_cause <= TRAP_ILLEGAL;
                        trap_pc    <= pc;
                        state      <= ST_HALT;
                    end else if (misaligned) begin
                        trap_cause <= TRAP_MISALIGNED;
                        trap_pc    <= pc; // pc not yet updated
                        state      <= ST_HALT;
                    end else begin
                        retire_valid <= 1'b1;
                        arvalid      <= 1'b1; // Next fetch overlaps retire
                        state        <= ST_FETCH_ADDR;
                    end
                end
                ST_HALT: state <= ST_HALT;
                default: state <= ST_HALT;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rready && rvalid)
            inst <= rdata;
    end

    // Commit trace payload
    always_ff @(posedge clk) begin
        if (commit) begin
            retire_pc    <= pc;
            retire_rd    <= writes_rd ? rd : 5'd0;
            retire_wdata <= (writes_rd && rd != 5'd0) ? wdata : 32'b0;
        end
    end

    ar_held_until_ready: assert property (
        @(posedge clk) disable iff (!rst_n)
        arvalid && !arready |=> arvalid && $stable(pc)
    );

    rready_in_data_phase: assert property (
        @(posedge clk) disable iff (!rst_n)
        rready |-> state == ST_FETCH_DATA && !arvalid
    );

    // An update leaves execute and retires while the next fetch starts
    updates_in_execute: assert property (
        @(posedge clk) disable iff (!rst_n)
        (pc_update || reg_we) |=> retire_valid && state == ST_FETCH_ADDR && arvalid
    );

endmodule

`default_nettype wire

// ==== rv_exec_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module rv_exec_top #(
    parameter logic [31:0] reset_pc = 32'h0000_0000
) (
    input  wire logic           clk,
    input  wire logic           rst_n,
    output logic                arvalid,
    input  wire logic           arready,
    output logic [31:0]         araddr,
    output logic [2:0]          arprot,
    input  wire logic           rvalid,
    output logic                rready,
    input  wire logic [31:0]    rdata,
    input  wire logic [1:0]     rresp,
    output logic                retire_valid,
    output logic [31:0]         retire_pc,
    output logic [4:0]          retire_rd,
    output logic [31:0]         retire_wdata,
    output logic                halted,
    output rv_pkg::trap_cause_e trap_cause,
    output logic [31:0]         trap_pc
);
    import rv_pkg::*;

    logic [31:0] inst;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [31:0] imm;
    alu_op_e     alu_op;
    inst_class_e inst_class;
    logic [2:0]  branch_func;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;
    logic [31:0] op_b;
    logic [31:0] alu_result;
    logic        branch_taken;
    logic [31:0] pc;
    logic [31:0] link;
    logic        misaligned;
    logic        pc_update;
    logic        reg_we;
    logic [31:0] wdata;

    assign araddr = pc;
    assign arprot = 3'b100; // Instruction, secure, unprivileged

    // Register operand for OP and branches, immediate otherwise
    assign op_b = (inst_class == CLS_BRANCH ||
                   (inst_class == CLS_ALU && opcode_e'(inst[6:2]) == OP)) ? rs2_data : imm;

    always_comb begin
        case (inst_class)
            CLS_LUI:            wdata = imm;
            CLS_AUIPC:          wdata = pc + imm;
            CLS_JAL, CLS_JALR:  wdata = link;
            default:            wdata = alu_result;
        endcase
    end

    core_ctrl core_ctrl_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .arvalid      (arvalid),
        .arready      (arready),
        .rvalid       (rvalid),
        .rready       (rready),
        .rdata        (rdata),
        .rresp        (rresp),
        .inst         (inst),
        .inst_class   (inst_class),
        .rd           (rd),
        .wdata        (wdata),
        .misaligned   (misaligned),
        .pc           (pc),
        .pc_update    (pc_update),
        .reg_we       (reg_we),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_rd    (retire_rd),
        .retire_wdata (retire_wdata),
        .halted       (halted),
        .trap_cause   (trap_cause),
        .trap_pc      (trap_pc)
    );

    pc_unit #(
        .reset_pc (reset_pc)
    ) pc_unit_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .pc_update    (pc_update),
        .inst_class   (inst_class),
        .branch_taken (branch_taken),
        .imm          (imm),
        .rs1_data     (rs1_data),
        .pc           (pc),
        .link         (link),
        .misaligned   (misaligned)
    );

    instr_decoder instr_decoder_inst (
        .inst        (inst),
        .rd          (rd),
        .rs1         (rs1),
        .rs2         (rs2),
        .imm         (imm),
        .alu_op      (alu_op),
        .inst_class  (inst_class),
        .branch_func (branch_func)
    );

    reg_file reg_file_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1      (rs1),
        .rs2      (rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .we       (reg_we),
        .rd       (rd),
        .wdata    (wdata)
    );

    alu alu_inst (
        .a            (rs1_data),
        .b            (op_b),
        .alu_op       (alu_op),
        .branch_func  (branch_func),
        .result       (alu_result),
        .branch_taken (branch_taken)
    );

endmodule

`default_nettype wire

// ==== tb_iss.svh ====
`ifndef TB_ISS_SVH
`define TB_ISS_SVH

// Reference model of the RV32I subset, included inside the testbench module

logic [31:0] xreg [32];
logic [31:0] mpc;
logic [31:0] want_pc [$];
logic [4:0]  want_rd [$];
logic [31:0] want_wdata [$];
trap_cause_e want_trap;
logic [31:0] want_trap_pc;
int          bus_err_word = -1; // Word that answers SLVERR, -1 for none

function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                        input logic [31:0] a, input logic [31:0] b);
    logic [31:0] r;
    case (f3)
        3'd0: r = alt ? a - b : a + b;
        3'd1: r = a << b[4:0];
        3'd2: r = {31'b0, $signed(a) < $signed(b)};
        3'd3: r = {31'b0, a < b};
        3'd4: r = a ^ b;
        3'd5: begin
            if (alt)
                r = $signed(a) >>> b[4:0];
            else
                r = a >> b[4:0];
        end
        3'd6: r = a | b;
        default: r = a & b;
    endcase
    return r;
endfunction

function automatic logic branch_ref(input logic [2:0] f3, input logic [31:0] a,
                                    input logic [31:0] b);
    case (f3)
        3'd0: return a == b;
        3'd1: return a != b;
        3'd4: return $signed(a) < $signed(b);
        3'd5: return $signed(a) >= $signed(b);
        3'd6: return a < b;
        default: return a >= b;
    endcase
endfunction

// Runs the program from boot_pc until a trap or max_commits commits
task automatic predict(input int max_commits);
    logic [31:0] ins;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] r;
    logic [31:0] nxt;
    logic [31:0] imm_i;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [4:0]  rd;
    logic        wr;
    logic        bad;
    want_pc.delete();
    want_rd.delete();
    want_wdata.delete();
    want_trap    = TRAP_NONE;
    want_trap_pc = 32'b0;
    for (int i = 0; i < 32; i++)
        xreg[i] = 32'b0;
    mpc = boot_pc;
    while (want_pc.size() < max_commits && want_trap == TRAP_NONE) begin
        ins   = mem[mpc[9:2]];
        a     = xreg[ins[19:15]];
        b     = xreg[ins[24:20]];
        f3    = ins[14:12];
        f7    = ins[31:25];
        rd    = ins[11:7];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        r     = 32'b0;
        nxt   = mpc + 32'd4;
        wr    = 1'b1;
        bad   = ins[1:0] != 2'b11;
        case (ins[6:2])
            OP: begin
                bad |= !(f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)));
                r = alu_ref(f3, f7[5], a, b);
            end
            OP_IMM: begin
                if (f3 == 3'd1)
                    bad |= f7 != 7'h00;
                if (f3 == 3'd5)
                    bad |= f7 != 7'h00 && f7 != 7'h20;
                r = alu_ref(f3, f3 == 3'd5 && f7[5], a, imm_i);
            end
            LUI:   r = {ins[31:12], 12'b0};
            AUIPC: r = mpc + {ins[31:12], 12'b0};
            JAL: begin
                r   = mpc + 32'd4;
                nxt = mpc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            end
            JALR: begin
                bad |= f3 != 3'd0;
                r   = mpc + 32'd4;
                nxt = (a + imm_i) & 32'hffff_fffe;
            end
            BRANCH: begin
                wr  = 1'b0;
                bad |= f3 == 3'd2 || f3 == 3'd3;
                if (branch_ref(f3, a, b))
                    nxt = mpc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
            end
            default: bad = 1'b1;
        endcase
        if (int'(mpc[9:2]) == bus_err_word) begin
            want_trap    = TRAP_BUS;
            want_trap_pc = mpc;
        end else if (bad) begin
            want_trap    = TRAP_ILLEGAL;
            want_trap_pc = mpc;
        end else if (nxt[1]) begin
            want_trap    = TRAP_MISALIGNED;
            want_trap_pc = mpc;
        end else begin
            if (!wr)
                rd = 5'd0;
            want_pc.push_back(mpc);
            want_rd.push_back(rd);
            want_wdata.push_back(rd != 5'd0 ? r : 32'b0);
            if (rd != 5'd0)
                xreg[rd] = r;
            mpc = nxt;
        end
    end
endtask

`endif

// ==== tb_rv_exec.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_rv_exec;
    import rv_pkg::*;

    localparam logic [31:0] boot_pc   = 32'h0000_0040;
    localparam int          boot_word = 16;
    localparam int          run_len   = 200; // Commits per test

    logic        clk = 1'b0;
    logic        rst_n = 1'b0;
    logic        arvalid;
    logic        arready = 1'b0;
    logic [31:0] araddr;
    logic [2:0]  arprot;
    logic        rvalid = 1'b0;
    logic        rready;
    logic [31:0] rdata = 32'b0;
    logic [1:0]  rresp = 2'b00;
    logic        retire_valid;
    logic [31:0] retire_pc;
    logic [4:0]  retire_rd;
    logic [31:0] retire_wdata;
    logic        halted;
    trap_cause_e trap_cause;
    logic [31:0] trap_pc;

    logic [31:0] mem [256];
    logic [31:0] lfsr = 32'hb633;
    int          max_delay;
    int          errors;
    int          tests_run;
    int          tests_failed;
    int          cycles;
    int          cycle_limit = 1000;
    int          seen;
    logic        armed = 1'b0;
    logic        halt_seen;
    logic        busy;
    logic [31:0] fetch_addr;
    int          ar_delay;
    int          ar_count;
    int          r_delay;
    int          r_count;

    `include "tb_iss.svh"

    rv_exec_top #(
        .reset_pc (boot_pc)
    ) rv_exec_top_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .arvalid      (arvalid),
        .arready      (arready),
        .araddr       (araddr),
        .arprot       (arprot),
        .rvalid       (rvalid),
        .rready       (rready),
        .rdata        (rdata),
        .rresp        (rresp),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_rd    (retire_rd),
        .retire_wdata (retire_wdata),
        .halted       (halted),
        .trap_cause   (trap_cause),
        .trap_pc      (trap_pc)
    );

    initial begin
        forever #20 clk = ~clk;
    end

    // Galois LFSR stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = 32'b0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic int pick_delay();
        if (max_delay == 0)
            return 0;
        return int'(rand_bits(4)) % (max_delay + 1);
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [4:0] opc);
        return {imm, rs1, f3, rd, opc, 2'b11};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, JAL, 2'b11};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], BRANCH, 2'b11};
    endfunction

    // OP or OP_IMM with a legal funct7
    function automatic logic [31:0] rand_alu();
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic        alt;
        logic [11:0] imm;
        rd  = 5'(rand_bits(5));
        rs1 = 5'(rand_bits(5));
        rs2 = 5'(rand_bits(5));
        f3  = 3'(rand_bits(3));
        alt = 1'(rand_bits(1));
        imm = 12'(rand_bits(12));
        if (rand_bits(1) == 32'd0)
            return {(alt && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00,
                    rs2, rs1, f3, rd, OP, 2'b11};
        if (f3 == 3'd1 || f3 == 3'd5)
            return {(alt && f3 == 3'd5) ? 7'h20 : 7'h00, rs2, rs1, f3, rd, OP_IMM, 2'b11};
        return enc_i(imm, rs1, f3, rd, OP_IMM);
    endfunction

    // mix 0 ALU, 1 upper and jumps, 2 branches on x0..x7, 3 any of these
    function automatic logic [31:0] rand_inst(input int mix);
        int          kind;
        int          sel;
        logic [5:0]  off;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [19:0] upper;
        logic [7:0]  tgt;
        logic [2:0]  f3;
        kind = (mix == 3) ? int'(rand_bits(2)) % 3 : mix;
        if (kind == 0)
            return rand_alu();
        sel   = int'(rand_bits(3));
        off   = 6'(rand_bits(6));
        upper = 20'(rand_bits(20));
        if (kind == 1) begin
            rd  = 5'(rand_bits(5));
            tgt = 8'(rand_bits(8));
            case (sel)
                0: return {upper, rd, LUI, 2'b11};
                1: return {upper, rd, AUIPC, 2'b11};
                2: return enc_j({{13{off[5]}}, off, 2'b00}, rd);
                3: return enc_i({2'b00, tgt, 1'b0, upper[0]}, 5'd0, 3'd0, rd, JALR);
                default: return rand_alu();
            endcase
        end
        rd  = 5'(rand_bits(3));
        rs1 = 5'(rand_bits(3));
        rs2 = 5'(rand_bits(3));
        if (sel < 2) begin
            case (upper[1:0]) // Sign and carry corners
                2'd0: upper = 20'h80000;
                2'd1: upper = 20'h7ffff;
                2'd2: upper = 20'hfffff;
                default: upper = 20'h00000;
            endcase
            return {upper, rd, LUI, 2'b11};
        end
        if (sel < 4)
            return enc_i({{6{off[5]}}, off}, rs1, 3'd0, rd, OP_IMM);
        sel = int'(rand_bits(3)) % 6;
        f3  = (sel < 2) ? 3'(sel) : 3'(sel + 2);
        return enc_b({{5{off[5]}}, off, 2'b00}, rs2, rs1, f3);
    endfunction

    function automatic logic [31:0] illegal_inst(input int kind);
        case (kind)
            0: return enc_i(12'h004, 5'd1, 3'b010, 5'd2, LOAD);
            1: return {7'h00, 5'd2, 5'd1, 3'b010, 5'd8, STORE, 2'b11};
            2: return enc_i(12'h300, 5'd1, 3'b001, 5'd2, SYSTEM); // csrrw
            default: return enc_b(13'd8, 5'd2, 5'd1, 3'b010);
        endcase
    endfunction

    task automatic build_program(input int mix);
        for (int i = 0; i < 256; i++)
            mem[i] = rand_inst(mix);
    endtask

    // AXI4-Lite read slave over a 1 KiB image
    always @(posedge clk) begin
        if (!rst_n) begin
            arready  <= 1'b0;
            rvalid   <= 1'b0;
            busy     <= 1'b0;
            ar_count <= 0;
            ar_delay <= 0;
        end else begin
            if (arvalid && arready) begin
                arready    <= 1'b0;
                busy       <= 1'b1;
                fetch_addr <= araddr;
                r_count    <= 0;
                r_delay    <= pick_delay();
            end else if (arvalid && !busy) begin
                if (ar_count >= ar_delay)
                    arready <= 1'b1;
                else
                    ar_count <= ar_count + 1;
            end
            if (rvalid && rready) begin
                rvalid   <= 1'b0;
                busy     <= 1'b0;
                ar_count <= 0;
                ar_delay <= pick_delay();
            end else if (busy && !rvalid) begin
                if (r_count >= r_delay) begin
                    rvalid <= 1'b1;
                    rdata  <= mem[fetch_addr[9:2]];
                    rresp  <= (int'(fetch_addr[9:2]) == bus_err_word) ? 2'b10 : AXI_RESP_OKAY;
                end else begin
                    r_count <= r_count + 1;
                end
            end
        end
    end

    // Commit trace and fetch attributes on the falling edge
    always @(negedge clk) begin
        if (armed && rst_n) begin
            if (halted)
                halt_seen = 1'b1;
            if (arvalid && arready)
                check_value("arprot instruction bit", 32'(arprot[2]), 32'd1);
            if (retire_valid) begin
                if (seen < want_pc.size()) begin
                    check_value("retire_pc", retire_pc, want_pc[seen]);
                    check_value("retire_rd", 32'(retire_rd), 32'(want_rd[seen]));
                    check_value("retire_wdata", retire_wdata, want_wdata[seen]);
                end else if (want_trap != TRAP_NONE) begin
                    errors++;
                    $display("error at %0t ns: retire after the last expected commit", $time);
                end
                seen++;
            end
        end
    end

    always @(negedge clk) begin
        cycles++;
        if (armed && cycles > cycle_limit) begin
            $display("Timeout: test %0d did not finish within %0d cycles", tests_run, cycle_limit);
            $display("Simulation failed");
            $finish;
        end
    end

    task automatic run_test(input string name, input int delay);
        int errs_before;
        errs_before = errors;
        tests_run++;
        max_delay   = delay;
        predict(run_len);
        cycle_limit = (run_len + 1) * (2 * delay + 5) + 100;
        seen        = 0;
        halt_seen   = 1'b0;
        repeat (3) @(posedge clk);
        cycles = 0;
        armed  = 1'b1;
        rst_n <= 1'b1;
        @(posedge clk);
        while (!((want_trap == TRAP_NONE) ? seen >= want_pc.size() : halt_seen))
            @(posedge clk);
        armed = 1'b0;
        check_value("commit count", seen, want_pc.size());
        check_value("halted", 32'(halted), 32'(want_trap != TRAP_NONE));
        check_value("trap_cause", 32'(trap_cause), 32'(want_trap));
        if (want_trap != TRAP_NONE)
            check_value("trap_pc", trap_pc, want_trap_pc);
        if (errors != errs_before)
            tests_failed++;
        $display("test %0d %-20s %s, %0d commits", tests_run, name,
                 (errors == errs_before) ? "pass" : "FAIL", seen);
        rst_n <= 1'b0;
        @(posedge clk);
    endtask

    initial begin
        @(posedge clk);
        build_program(0);
        run_test("alu_random", 3);
        build_program(1);
        run_test("upper_and_jumps", 3);
        build_program(2);
        run_test("branches", 3);
        for (int k = 0; k < 4; k++) begin
            build_program(0);
            mem[boot_word + 40] = illegal_inst(k);
            run_test($sformatf("illegal_%0d", k), 2);
        end
        build_program(0);
        mem[boot_word + 30] = enc_j(21'd6, 5'd1); // Target bit 1 set
        run_test("misaligned_jal", 2);
        build_program(0);
        mem[boot_word + 35] = enc_b(13'd6, 5'd0, 5'd0, 3'b000);
        run_test("misaligned_branch", 2);
        build_program(0);
        bus_err_word = boot_word + 50;
        run_test("bus_error", 2);
        bus_err_word = -1;
        build_program(3);
        run_test("mixed_no_delay", 0);
        run_test("mixed_backpressure", 15); // Same image and same trace
        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== rv_exec.f ====
+incdir+.
rv_pkg.sv
instr_decoder.sv
alu.sv
reg_file.sv
pc_unit.sv
core_ctrl.sv
rv_exec_top.sv
tb_rv_exec.sv

// ==== Bender.yml ====
package:
  name: rv_exec

sources:
  - rv_pkg.sv
  - instr_decoder.sv
  - alu.sv
  - reg_file.sv
  - pc_unit.sv
  - core_ctrl.sv
  - rv_exec_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_rv_exec.sv
